//--- dv/tb_scan_table.svh
`ifndef TB_SCAN_TABLE_SVH
`define TB_SCAN_TABLE_SVH

localparam int PAUSE_CYCLES = 400;  // long enough to drain fifo and writer
localparam int NUM_ROWS     = 2 + 2 * LINES_PER_FRAME * POINTS_PER_LINE * 2;  // setup + 2 frames

typedef struct {
  logic [23:0] word;       // expected spi word
  logic [1:0]  flags;      // {new_line, new_frame} after the word
  logic        pause;      // hold pause before this x word
  int          ack_delay;  // cycles until the flags are acked
} scan_row_t;

scan_row_t scan_table [NUM_ROWS];
string     row_name [NUM_ROWS];
int        row_count = 0;
int        pause_count = 0;

task automatic add_row(input logic [23:0] word, input logic [1:0] flags,
                       input logic pse, input int delay, input string name);
  scan_table[row_count].word      = word;
  scan_table[row_count].flags     = flags;
  scan_table[row_count].pause     = pse;
  scan_table[row_count].ack_delay = delay;
  row_name[row_count]             = name;
  row_count++;
  if (pse) pause_count++;
endtask

// setup words, then x/y per point, raster wraps after each frame
task automatic build_table();
  int f;
  int l;
  int p;
  int draw;
  logic [1:0] tags;
  add_row({DAC_CMD_RESET, 4'd0, 16'd0}, 2'b00, 1'b0, 0, "setup reset");
  add_row({DAC_CMD_REF, 4'd0, 16'd0}, 2'b00, 1'b0, 0, "setup ref");  // external ref
  for (f = 0; f < 2; f++) begin
    for (l = 0; l < LINES_PER_FRAME; l++) begin
      for (p = 0; p < POINTS_PER_LINE; p++) begin
        draw_bits(3, draw);  // roughly one pause in eight points
        add_row({DAC_CMD_WRITE, DAC_CH_X, 16'(p * X_STEP)}, 2'b00, draw == 0, 0,
                $sformatf("frame %0d line %0d point %0d x", f, l, p));
        tags = {(p == POINTS_PER_LINE - 1),
                (p == POINTS_PER_LINE - 1) && (l == LINES_PER_FRAME - 1)};
        draw = 0;
        if (tags != 2'b00) draw_bits(5, draw);  // ack delay only for tagged words
        add_row({DAC_CMD_WRITE, DAC_CH_Y, 16'(l * Y_STEP)}, tags, 1'b0, draw + 1,
                $sformatf("frame %0d line %0d point %0d y", f, l, p));
      end
    end
  end
endtask

`endif

//--- dv/tb_mems_scan.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mems_scan;
  import mems_scan_pkg::*;

  logic clk = 1'b0;
  logic mems_soft_reset;
  logic start;
  logic pause;
  logic line_ack;
  logic frame_ack;
  logic sclk;
  logic sync_n;
  logic mosi;
  logic new_line;
  logic new_frame;

  logic [15:0] lfsr = 16'd16787;
  int          cycle = 0;
  int          pause_until = 0;  // pause held while cycle is below this
  int          ack_at = -1;      // cycle of the next ack pulse
  logic [1:0]  ack_flags = 2'b00;
  logic [3:0]  last_ch = 4'd0;   // channel of last word out
  int          rows_done = 0;
  logic        table_ready = 1'b0;

  `include "tb_scan_table.svh"

  mems_scan_top DUT (.*);

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output int val);
    int k;
    val = 0;
    for (k = 0; k < n; k++) begin
      lfsr = lfsr_step(lfsr);  // one step per bit
      val  = (val << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act) else begin
      $display("** Error %s: expected %0h, actual %0h", name, exp, act);
      $display("** FAIL **");
      $fatal(1, "value mismatch");
    end
  endtask

  // one sync_n frame, bits taken on rising sclk, sampled at falling clk
  task automatic capture_word(output logic [23:0] word, output int low_cnt, output int bits);
    logic prev_sclk;
    word      = '0;
    low_cnt   = 0;
    bits      = 0;
    prev_sclk = 1'b0;
    while (sync_n) @(negedge clk);
    while (!sync_n) begin
      low_cnt++;
      if (sclk && !prev_sclk) begin
        word = {word[22:0], mosi};
        bits++;
      end
      prev_sclk = sclk;
      @(negedge clk);
    end
  endtask

  initial forever #2 clk = ~clk;  // 4 ns period

  always @(posedge clk) cycle <= cycle + 1;

  initial begin
    pause = 1'b0;
    forever begin
      @(negedge clk);
      if (pause && cycle >= pause_until) begin
        // pipe drained, so the stall must sit between points
        check_value("writer idle at pause end", 1, 32'(sync_n));
        check_value("pause boundary channel", 32'(DAC_CH_Y), 32'(last_ch));
      end
      pause = (cycle < pause_until);
    end
  end

  initial begin
    line_ack  = 1'b0;
    frame_ack = 1'b0;
    forever begin
      @(negedge clk);
      line_ack  = 1'b0;
      frame_ack = 1'b0;
      if (cycle == ack_at) begin
        // sticky until now
        if (ack_flags[1]) check_value("new_line held until ack", 1, 32'(new_line));
        if (ack_flags[0]) check_value("new_frame held until ack", 1, 32'(new_frame));
        line_ack  = ack_flags[1];
        frame_ack = ack_flags[0];
      end
    end
  end

  initial begin
    int limit;
    wait (table_ready);
    limit = NUM_ROWS * 50 + pause_count * PAUSE_CYCLES + 1000;  // 50 cycles per word
    repeat (limit) @(posedge clk);
    $display("scan stalled, only %0d of %0d words seen", rows_done, NUM_ROWS);
    $display("** FAIL **");
    $fatal(1, "watchdog timeout");
  end

  initial begin
    logic [23:0] got;
    int low_cnt;
    int bits;
    int i;
    mems_soft_reset = 1'b1;
    start           = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (8) @(negedge clk);
    mems_soft_reset = 1'b0;
    repeat (20) begin  // nothing moves before start
      @(negedge clk);
      check_value("idle sync_n before start", 1, 32'(sync_n));
      check_value("idle flags before start", 0, 32'({new_line, new_frame}));
    end
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    for (i = 0; i < NUM_ROWS; i++) begin
      if (scan_table[i].pause) pause_until = cycle + PAUSE_CYCLES;
      capture_word(got, low_cnt, bits);
      check_value({row_name[i], " word"}, 32'(scan_table[i].word), 32'(got));
      check_value({row_name[i], " bit count"}, 24, bits);
      check_value({row_name[i], " sync_n low cycles"}, 48, low_cnt);
      last_ch = got[19:16];
      rows_done++;
      // flags set as sync_n rises
      check_value({row_name[i], " flags"}, 32'(scan_table[i].flags), 32'({new_line, new_frame}));
      if (scan_table[i].flags != 2'b00) begin
        ack_flags = scan_table[i].flags;
        ack_at    = cycle + scan_table[i].ack_delay;
      end
    end
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

//--- mems_scan.f
+incdir+dv
src/mems_scan_pkg.sv
src/dac_link_if.sv
src/scan_sequencer.sv
src/dac_cmd_fifo.sv
src/dac_spi_writer.sv
src/mems_scan_top.sv
dv/tb_mems_scan.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, then run it
# the simulator exit status is the verdict
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f mems_scan.f --top-module tb_mems_scan -o tb_mems_scan
./obj_dir/tb_mems_scan

//--- src/dac_cmd_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module dac_cmd_fifo #(
  parameter int depth = mems_scan_pkg::FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     mems_soft_reset,
  dac_link_if.recv in_link,
  dac_link_if.send out_link
);
  import mems_scan_pkg::*;

  typedef logic [$clog2(depth)-1:0]            ptr_t;
  typedef logic [$clog2(depth+1)-1:0]          fill_t;
  typedef logic [$clog2(WRITER_CREDITS+1)-1:0] wcred_t;

  dac_entry_t mem [depth];  // entry storage
  ptr_t       wr_ptr;
  ptr_t       rd_ptr;
  fill_t      fill;       // entries held
  wcred_t     wr_credit;  // writer slots we may use
  logic       send;

  // oldest entry goes out once the writer has room
  assign send = (fill != '0) && (wr_credit != '0);

  assign out_link.valid = send;
  assign out_link.entry = mem[rd_ptr];
  assign in_link.credit = send;  // slot freed the same cycle

  always_ff @(posedge clk) begin
    if (in_link.valid) begin
      mem[wr_ptr] <= in_link.entry;
    end
  end

  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      fill      <= '0;
      wr_credit <= wcred_t'(WRITER_CREDITS);
    end else begin
      if (in_link.valid) begin
        wr_ptr <= (wr_ptr == ptr_t'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= (rd_ptr == ptr_t'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end

      case ({in_link.valid, send})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: ;
      endcase

      case ({send, out_link.credit})
        2'b10:   wr_credit <= wr_credit - 1'b1;
        2'b01:   wr_credit <= wr_credit + 1'b1;
        default: ;
      endcase
    end
  end

  // sender must have run out of credit before we fill up
  a_no_overflow : assert property (@(posedge clk) disable iff (mems_soft_reset)
    in_link.valid |-> (fill != fill_t'(depth)))
    else $error("write into full fifo, credit breach");

  // holding every writer credit means nothing is out to come back
  a_wr_credit_bound : assert property (@(posedge clk) disable iff (mems_soft_reset)
    out_link.credit |-> (wr_credit != wcred_t'(WRITER_CREDITS)))
    else $error("writer returned extra credit");

endmodule

`default_nettype wire

//--- src/dac_link_if.sv
`timescale 1ns/10ps
`default_nettype none

// credit based word link
// sender spends one credit per valid, receiver pulses credit to give it back
interface dac_link_if;
  import mems_scan_pkg::*;

  logic       valid;   // one cycle per word
  dac_entry_t entry;   // word plus line/frame tags
  logic       credit;  // one cycle per freed slot

  modport send (
    output valid,
    output entry,
    input  credit
  );

  modport recv (
    input  valid,
    input  entry,
    output credit
  );

endinterface

`default_nettype wire

//--- src/dac_spi_writer.sv
`timescale 1ns/10ps
`default_nettype none

module dac_spi_writer (
  input  logic     clk,
  input  logic     mems_soft_reset,
  dac_link_if.recv link,
  input  logic     line_ack,
  input  logic     frame_ack,
  output logic     sclk,
  output logic     sync_n,
  output logic     mosi,
  output logic     new_line,
  output logic     new_frame
);
  import mems_scan_pkg::*;

  localparam int WORD_BITS = $bits(dac_word_t);

  typedef logic [$clog2(WORD_BITS)-1:0] bit_t;
  typedef logic [$clog2(SCLK_DIV)-1:0]  phase_t;

  logic [WORD_BITS-1:0] shreg;  // msb on the wire
  logic   tag_line;
  logic   tag_frame;
  logic   busy;       // frame in progress
  bit_t   bit_cnt;    // bits left after this one
  phase_t phase;      // position inside one bit
  logic   credit_q;
  logic   line_q;
  logic   frame_q;
  logic   bit_end;
  logic   word_end;

  assign bit_end  = (phase == phase_t'(SCLK_DIV - 1));
  assign word_end = busy && bit_end && (bit_cnt == '0);

  // payload, loaded on valid and shifted at each bit end
  always_ff @(posedge clk) begin
    if (link.valid) begin
      shreg     <= link.entry.word;
      tag_line  <= link.entry.line_end;
      tag_frame <= link.entry.frame_end;
    end else if (busy && bit_end) begin
      shreg <= {shreg[WORD_BITS-2:0], 1'b0};  // next bit while sclk low
    end
  end

  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      busy     <= 1'b0;
      phase    <= '0;
      bit_cnt  <= '0;
      credit_q <= 1'b0;
      line_q   <= 1'b0;
      frame_q  <= 1'b0;
    end else begin
      credit_q <= word_end;  // pulse during the sync_n high gap
      if (link.valid) begin
        busy    <= 1'b1;
        phase   <= '0;
        bit_cnt <= bit_t'(WORD_BITS - 1);
      end else if (busy) begin
        if (bit_end) begin
          phase <= '0;
          if (bit_cnt == '0) busy <= 1'b0;
          else bit_cnt <= bit_cnt - 1'b1;
        end else begin
          phase <= phase + 1'b1;
        end
      end

      // sticky flags, a new set beats an ack
      if (word_end && tag_line) line_q <= 1'b1;
      else if (line_ack) line_q <= 1'b0;
      if (word_end && tag_frame) frame_q <= 1'b1;
      else if (frame_ack) frame_q <= 1'b0;
    end
  end

  assign link.credit = credit_q;
  assign sync_n      = ~busy;
  assign sclk        = busy && (phase >= phase_t'(SCLK_DIV / 2));  // rises mid bit
  assign mosi        = busy && shreg[WORD_BITS-1];
  assign new_line    = line_q;
  assign new_frame   = frame_q;

  // fifo must wait for our credit before the next word
  a_no_load_busy : assert property (@(posedge clk) disable iff (mems_soft_reset)
    link.valid |-> !busy)
    else $error("word offered while shifting");

  // sclk moves only once sync_n has been low a cycle
  // so the last fall lands as sync_n rises
  a_sclk_framed : assert property (@(posedge clk) disable iff (mems_soft_reset)
    $changed(sclk) |-> !$past(sync_n))
    else $error("sclk toggled outside sync_n frame");

endmodule

`default_nettype wire

//--- src/mems_scan_pkg.sv
`timescale 1ns/10ps
`default_nettype none

package mems_scan_pkg;

  // one dac frame as shifted out, msb first
  typedef struct packed {
    logic [3:0]  cmd;    // command nibble
    logic [3:0]  ch;     // channel address
    logic [15:0] value;  // dac code
  } dac_word_t;

  // word plus raster position tags
  typedef struct packed {
    dac_word_t word;
    logic      line_end;   // last write of a line
    logic      frame_end;  // last write of a frame
  } dac_entry_t;

  // dac command codes
  localparam logic [3:0] DAC_CMD_WRITE = 4'h3;  // write and update channel
  localparam logic [3:0] DAC_CMD_RESET = 4'h7;  // software reset
  localparam logic [3:0] DAC_CMD_REF   = 4'h8;  // ref setup, value 0 = external

  // mirror axes
  localparam logic [3:0] DAC_CH_X = 4'd0;
  localparam logic [3:0] DAC_CH_Y = 4'd1;

  // raster geometry
  localparam int POINTS_PER_LINE = 8;
  localparam int LINES_PER_FRAME = 4;
  localparam int X_STEP          = 4096;  // code step per point
  localparam int Y_STEP          = 8192;  // code step per line

  // flow control
  localparam int FIFO_DEPTH     = 4;  // also sequencer start credit
  localparam int WRITER_CREDITS = 1;  // writer holds one word at a time

  localparam int SCLK_DIV = 2;  // clk cycles per spi bit

endpackage

`default_nettype wire

//--- src/mems_scan_top.sv
`timescale 1ns/10ps
`default_nettype none

module mems_scan_top (
  input  logic clk,
  input  logic mems_soft_reset,
  input  logic start,      // kicks off dac setup then raster
  input  logic pause,      // holds off next point
  input  logic line_ack,   // clears new_line
  input  logic frame_ack,  // clears new_frame
  output logic sclk,
  output logic sync_n,
  output logic mosi,
  output logic new_line,
  output logic new_frame
);

  dac_link_if seq_link ();  // sequencer to fifo
  dac_link_if wr_link ();   // fifo to spi writer

  scan_sequencer u_seq (
    .clk             (clk),
    .mems_soft_reset (mems_soft_reset),
    .start           (start),
    .pause           (pause),
    .link            (seq_link)
  );

  dac_cmd_fifo u_fifo (
    .clk             (clk),
    .mems_soft_reset (mems_soft_reset),
    .in_link         (seq_link),
    .out_link        (wr_link)
  );

  dac_spi_writer u_writer (
    .clk             (clk),
    .mems_soft_reset (mems_soft_reset),
    .link            (wr_link),
    .line_ack        (line_ack),
    .frame_ack       (frame_ack),
    .sclk            (sclk),
    .sync_n          (sync_n),
    .mosi            (mosi),
    .new_line        (new_line),
    .new_frame       (new_frame)
  );

endmodule

`default_nettype wire

//--- src/scan_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module scan_sequencer (
  input  logic       clk,
  input  logic       mems_soft_reset,
  input  logic       start,
  input  logic       pause,
  dac_link_if.send   link
);
  import mems_scan_pkg::*;

  typedef enum logic [1:0] {IDLE, SEND_RESET, SEND_REF, SCAN} state_t;
  typedef logic [$clog2(FIFO_DEPTH+1)-1:0]    credit_t;
  typedef logic [$clog2(POINTS_PER_LINE)-1:0] point_t;
  typedef logic [$clog2(LINES_PER_FRAME)-1:0] line_t;

  state_t     state;
  credit_t    credit_cnt;  // free fifo slots
  point_t     point_cnt;
  line_t      line_cnt;
  logic       y_phase;     // 0 = x word next, 1 = y word next
  logic       has_credit;
  logic       last_point;
  logic       last_line;
  logic       push;
  dac_entry_t next_entry;

  assign has_credit = (credit_cnt != '0);
  assign last_point = (point_cnt == point_t'(POINTS_PER_LINE - 1));
  assign last_line  = (line_cnt == line_t'(LINES_PER_FRAME - 1));

  // word to offer this cycle
  always_comb begin
    push       = 1'b0;
    next_entry = '0;
    case (state)
      SEND_RESET: begin
        push                 = has_credit;
        next_entry.word.cmd  = DAC_CMD_RESET;
      end
      SEND_REF: begin
        push                 = has_credit;
        next_entry.word.cmd  = DAC_CMD_REF;  // value stays 0, external ref
      end
      SCAN: begin
        // pause only holds off the x word, a started point always finishes
        push                = has_credit && (y_phase || !pause);
        next_entry.word.cmd = DAC_CMD_WRITE;
        if (y_phase) begin
          next_entry.word.ch    = DAC_CH_Y;
          next_entry.word.value = 16'(line_cnt * Y_STEP);
          next_entry.line_end   = last_point;
          next_entry.frame_end  = last_point && last_line;
        end else begin
          next_entry.word.ch    = DAC_CH_X;
          next_entry.word.value = 16'(point_cnt * X_STEP);
        end
      end
      default: ;  // idle offers nothing
    endcase
  end

  assign link.valid = push;
  assign link.entry = next_entry;

  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      state      <= IDLE;
      credit_cnt <= credit_t'(FIFO_DEPTH);  // fifo starts empty
      point_cnt  <= '0;
      line_cnt   <= '0;
      y_phase    <= 1'b0;
    end else begin
      case ({push, link.credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: ;  // both or neither, no change
      endcase

      case (state)
        IDLE:       if (start) state <= SEND_RESET;
        SEND_RESET: if (push) state <= SEND_REF;
        SEND_REF:   if (push) state <= SCAN;
        SCAN: begin
          if (push) begin
            y_phase <= ~y_phase;
            if (y_phase) begin  // point done, step raster
              if (last_point) begin
                point_cnt <= '0;
                line_cnt  <= last_line ? '0 : line_cnt + 1'b1;
              end else begin
                point_cnt <= point_cnt + 1'b1;
              end
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // fifo must never hand back more slots than it has
  a_credit_bound : assert property (@(posedge clk) disable iff (mems_soft_reset)
    credit_cnt <= credit_t'(FIFO_DEPTH))
    else $error("sequencer credit above fifo depth");

endmodule

`default_nettype wire
